//--- Bender.yml
package:
  name: itlb

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/sv32_pkg.sv
      - hw/itlb_pkg.sv
      - hw/tlb_array_if.sv
      - hw/itlb_array.sv
      - hw/itlb_ctrl.sv
      - hw/itlb_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_clk_gen.sv
      - test/itlb_tb.sv

//--- hw/itlb_array.sv
/* Set-associative TLB page array */

`include "itlb_cfg.svh"

module itlb_array #(
    parameter int NUM_SETS  = `ITLB_4KB_ENTRIES / `ITLB_4KB_ASSOC,
    parameter int ASSOC     = `ITLB_4KB_ASSOC,
    parameter bit SUPERPAGE = 1'b0
) (
    input logic        CLK,
    input logic        nRST,
    tlb_array_if.array port
);

    localparam int IDX_W   = (NUM_SETS > 1) ? $clog2(NUM_SETS) : 1;
    localparam int WAY_W   = $clog2(ASSOC);
    // superpages compare and index on vpn1 only
    localparam int TAG_LSB = SUPERPAGE ? 10 : 0;

    itlb_pkg::tlb_entry_t entry_q [NUM_SETS][ASSOC];
    logic [ASSOC-1:0]     valid_q [NUM_SETS];
    // heap-ordered tree, node 1 is the root
    logic [ASSOC-1:1]     plru_q  [NUM_SETS];

    logic [IDX_W-1:0]     rd_idx;
    logic [IDX_W-1:0]     wr_idx;
    logic [ASSOC-1:0]     way_hit;
    logic [WAY_W-1:0]     hit_way;
    logic [WAY_W-1:0]     victim_way;

    function automatic logic [IDX_W-1:0] set_index(input sv32_pkg::vpn_t vpn,
                                                   input sv32_pkg::asid_t asid);
        return vpn[TAG_LSB +: IDX_W] ^ asid[IDX_W-1:0];
    endfunction

    // follow the tree bits down to a leaf
    function automatic logic [WAY_W-1:0] plru_victim(input logic [ASSOC-1:1] tree);
        int unsigned node;
        node = 1;
        for (int lvl = 0; lvl < WAY_W; lvl++) begin
            node = 2 * node + tree[node];
        end
        return WAY_W'(node - ASSOC);
    endfunction

    // point every node on the path away from the used way
    function automatic logic [ASSOC-1:1] plru_touch(input logic [ASSOC-1:1] tree,
                                                    input logic [WAY_W-1:0] way);
        logic [ASSOC-1:1] tree_n;
        logic             dir;
        int unsigned      node;
        tree_n = tree;
        node = 1;
        for (int lvl = WAY_W - 1; lvl >= 0; lvl--) begin
            dir = way[lvl];
            tree_n[node] = ~dir;
            node = 2 * node + dir;
        end
        return tree_n;
    endfunction

    // --------------------------------------------------
    // lookup

    always_comb begin
        rd_idx = set_index(port.rd_vpn, port.rd_asid);
        wr_idx = set_index(port.wr_vpn, port.wr_asid);
        for (int w = 0; w < ASSOC; w++) begin
            way_hit[w] = valid_q[rd_idx][w]
                && entry_q[rd_idx][w].vpn[19:TAG_LSB] == port.rd_vpn[19:TAG_LSB]
                && (entry_q[rd_idx][w].asid == port.rd_asid || entry_q[rd_idx][w].pte.g);
        end
    end

    // lowest matching way
    always_comb begin
        hit_way = '0;
        for (int w = ASSOC - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    assign port.hit             = |way_hit;
    assign port.sf_hit_way_mask = way_hit;
    assign victim_way           = plru_victim(plru_q[wr_idx]);

    always_comb begin
        port.hit_entry       = entry_q[rd_idx][hit_way];
        port.hit_entry.valid = valid_q[rd_idx][hit_way];
    end

    // --------------------------------------------------
    // state update

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else begin
            if (port.wr_valid && port.wr_fill) begin
                valid_q[wr_idx][victim_way] <= port.wr_entry.valid;
            end else if (port.wr_valid) begin
                valid_q[wr_idx] <= valid_q[wr_idx] & ~port.wr_inv_mask;
            end
            // a fill counts as a use of the victim
            if (port.wr_valid && port.wr_fill) begin
                plru_q[wr_idx] <= plru_touch(plru_q[wr_idx], victim_way);
            end else if (port.touch_valid) begin
                plru_q[rd_idx] <= plru_touch(plru_q[rd_idx], hit_way);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (port.wr_valid && port.wr_fill) begin
            entry_q[wr_idx][victim_way] <= port.wr_entry;
        end
    end

endmodule

//--- hw/itlb_ctrl.sv
/* ITLB controller */

`include "itlb_cfg.svh"

module itlb_ctrl (
    input  logic                 CLK,
    input  logic                 nRST,
    tlb_array_if.ctrl            arr_4kb,
    tlb_array_if.ctrl            arr_4mb,
    input  logic                 core_req_valid,
    input  sv32_pkg::exec_mode_t core_req_exec_mode,
    input  logic                 core_req_virtual_mode,
    input  sv32_pkg::asid_t      core_req_asid,
    input  sv32_pkg::vpn_t       core_req_vpn,
    output logic                 core_req_ready,
    output logic                 core_resp_valid,
    output sv32_pkg::ppn_t       core_resp_ppn,
    output logic                 core_resp_page_fault,
    output logic                 l2_tlb_req_valid,
    output sv32_pkg::asid_t      l2_tlb_req_asid,
    output sv32_pkg::vpn_t       l2_tlb_req_vpn,
    input  logic                 l2_tlb_req_ready,
    input  logic                 l2_tlb_resp_valid,
    input  sv32_pkg::asid_t      l2_tlb_resp_asid,
    input  sv32_pkg::vpn_t       l2_tlb_resp_vpn,
    input  sv32_pkg::pte_t       l2_tlb_resp_pte,
    input  logic                 l2_tlb_resp_is_superpage,
    input  logic                 sfence_inv_valid,
    input  sv32_pkg::asid_t      sfence_inv_asid,
    input  sv32_pkg::vpn_t       sfence_inv_vpn,
    output logic                 sfence_inv_ready
);

    itlb_pkg::ctrl_state_t       state_q;
    itlb_pkg::ctrl_state_t       state_d;
    logic                        in_fill;
    logic                        sf_accept;
    logic                        sf_write;
    logic                        core_accept;
    logic                        lookup_hit;
    logic                        hit_super;
    sv32_pkg::pte_t              hit_pte;
    logic                        resp_valid_d;
    logic                        resp_fault_d;
    sv32_pkg::ppn_t              resp_ppn_d;
    // miss register
    sv32_pkg::asid_t             miss_asid_q;
    sv32_pkg::vpn_t              miss_vpn_q;
    sv32_pkg::exec_mode_t        miss_mode_q;
    itlb_pkg::tlb_entry_t        fill_entry_q;
    logic                        fill_super_q;
    // sfence second stage
    logic                        sf_pend_q;
    sv32_pkg::asid_t             sf_asid_q;
    sv32_pkg::vpn_t              sf_vpn_q;
    logic [`ITLB_4KB_ASSOC-1:0]  sf_mask_4kb_q;
    logic [`ITLB_4MB_ASSOC-1:0]  sf_mask_4mb_q;

    function automatic logic page_fault(input sv32_pkg::pte_t pte, input logic is_super,
                                        input sv32_pkg::exec_mode_t mode);
        return !pte.v || !pte.x
            || (mode == sv32_pkg::MODE_USER && !pte.u)
            || (mode == sv32_pkg::MODE_SUPERVISOR && pte.u)
            || (is_super && pte.ppn0 != '0);
    endfunction

    // superpages take the page offset bits from vpn0
    function automatic sv32_pkg::ppn_t page_ppn(input sv32_pkg::pte_t pte, input logic is_super,
                                                input sv32_pkg::vpn_t vpn);
        return is_super ? {pte.ppn1, vpn[9:0]} : {pte.ppn1, pte.ppn0};
    endfunction

    // --------------------------------------------------
    // port arbitration

    assign in_fill          = state_q == itlb_pkg::FILL;
    assign sfence_inv_ready = !sf_pend_q && !in_fill;
    assign sf_accept        = sfence_inv_valid && sfence_inv_ready;
    // sfence takes the read port first
    assign core_req_ready   = state_q == itlb_pkg::IDLE && !sf_accept;
    assign core_accept      = core_req_valid && core_req_ready;
    // fill takes the write port first
    assign sf_write         = sf_pend_q && !in_fill;

    assign arr_4kb.rd_vpn      = sf_accept ? sfence_inv_vpn : core_req_vpn;
    assign arr_4kb.rd_asid     = sf_accept ? sfence_inv_asid : core_req_asid;
    assign arr_4mb.rd_vpn      = arr_4kb.rd_vpn;
    assign arr_4mb.rd_asid     = arr_4kb.rd_asid;
    assign arr_4kb.touch_valid = core_accept && core_req_virtual_mode && arr_4kb.hit;
    assign arr_4mb.touch_valid = core_accept && core_req_virtual_mode && !arr_4kb.hit
                                 && arr_4mb.hit;

    assign arr_4kb.wr_valid    = (in_fill && !fill_super_q) || sf_write;
    assign arr_4mb.wr_valid    = (in_fill && fill_super_q) || sf_write;
    assign arr_4kb.wr_fill     = in_fill;
    assign arr_4mb.wr_fill     = in_fill;
    assign arr_4kb.wr_vpn      = in_fill ? fill_entry_q.vpn : sf_vpn_q;
    assign arr_4mb.wr_vpn      = arr_4kb.wr_vpn;
    assign arr_4kb.wr_asid     = in_fill ? fill_entry_q.asid : sf_asid_q;
    assign arr_4mb.wr_asid     = arr_4kb.wr_asid;
    assign arr_4kb.wr_entry    = fill_entry_q;
    assign arr_4mb.wr_entry    = fill_entry_q;
    assign arr_4kb.wr_inv_mask = sf_mask_4kb_q;
    assign arr_4mb.wr_inv_mask = sf_mask_4mb_q;

    assign l2_tlb_req_valid    = state_q == itlb_pkg::MISS_REQ;
    assign l2_tlb_req_asid     = miss_asid_q;
    assign l2_tlb_req_vpn      = miss_vpn_q;

    // --------------------------------------------------
    // response and miss FSM

    always_comb begin
        lookup_hit   = arr_4kb.hit || arr_4mb.hit;
        hit_super    = !arr_4kb.hit;
        hit_pte      = arr_4kb.hit ? arr_4kb.hit_entry.pte : arr_4mb.hit_entry.pte;
        resp_valid_d = in_fill || (core_accept && (!core_req_virtual_mode || lookup_hit));
        if (in_fill) begin
            resp_fault_d = page_fault(fill_entry_q.pte, fill_super_q, miss_mode_q);
            resp_ppn_d   = page_ppn(fill_entry_q.pte, fill_super_q, miss_vpn_q);
        end else if (core_req_virtual_mode) begin
            resp_fault_d = page_fault(hit_pte, hit_super, core_req_exec_mode);
            resp_ppn_d   = page_ppn(hit_pte, hit_super, core_req_vpn);
        end else begin
            // bare mode
            resp_fault_d = 1'b0;
            resp_ppn_d   = sv32_pkg::ppn_t'(core_req_vpn);
        end
        if (resp_fault_d) begin
            resp_ppn_d = '0;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            itlb_pkg::IDLE: begin
                if (core_accept && core_req_virtual_mode && !lookup_hit) begin
                    state_d = itlb_pkg::MISS_REQ;
                end
            end
            itlb_pkg::MISS_REQ: begin
                if (l2_tlb_req_ready) begin
                    state_d = itlb_pkg::MISS_WAIT;
                end
            end
            itlb_pkg::MISS_WAIT: begin
                if (l2_tlb_resp_valid) begin
                    state_d = itlb_pkg::FILL;
                end
            end
            default: state_d = itlb_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q         <= itlb_pkg::IDLE;
            core_resp_valid <= 1'b0;
            sf_pend_q       <= 1'b0;
        end else begin
            state_q         <= state_d;
            core_resp_valid <= resp_valid_d;
            if (sf_accept) begin
                sf_pend_q <= 1'b1;
            end else if (sf_write) begin
                sf_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (resp_valid_d) begin
            core_resp_ppn        <= resp_ppn_d;
            core_resp_page_fault <= resp_fault_d;
        end
        if (core_accept) begin
            miss_asid_q <= core_req_asid;
            miss_vpn_q  <= core_req_vpn;
            miss_mode_q <= core_req_exec_mode;
        end
        if (state_q == itlb_pkg::MISS_WAIT && l2_tlb_resp_valid) begin
            fill_entry_q.valid <= 1'b1;
            fill_entry_q.asid  <= l2_tlb_resp_asid;
            fill_entry_q.vpn   <= l2_tlb_resp_vpn;
            fill_entry_q.pte   <= l2_tlb_resp_pte;
            fill_super_q       <= l2_tlb_resp_is_superpage;
        end
        // matched ways are cleared in the next free write cycle
        if (sf_accept) begin
            sf_asid_q     <= sfence_inv_asid;
            sf_vpn_q      <= sfence_inv_vpn;
            sf_mask_4kb_q <= arr_4kb.sf_hit_way_mask;
            sf_mask_4mb_q <= arr_4mb.sf_hit_way_mask;
        end
    end

endmodule

//--- hw/itlb_pkg.sv
/* ITLB internal types */

package itlb_pkg;

    // --------------------------------------------------
    // array entry

    // full vpn kept since the set index is hashed with the asid
    typedef struct packed {
        logic            valid;
        sv32_pkg::asid_t asid;
        sv32_pkg::vpn_t  vpn;
        sv32_pkg::pte_t  pte;
    } tlb_entry_t;

    // --------------------------------------------------
    // controller FSM

    // IDLE       lookups from the core
    // MISS_REQ   request held toward the L2 TLB
    // MISS_WAIT  waiting for the L2 response pulse
    // FILL       array write and replayed response
    typedef enum logic [1:0] {
        IDLE,
        MISS_REQ,
        MISS_WAIT,
        FILL
    } ctrl_state_t;

endpackage

//--- hw/itlb_top.sv
/* Sv32 L1 instruction TLB */

`include "itlb_cfg.svh"

module itlb_top (
    input  logic                 CLK,
    input  logic                 nRST,
    // core request
    input  logic                 core_req_valid,
    input  sv32_pkg::exec_mode_t core_req_exec_mode,
    input  logic                 core_req_virtual_mode,
    input  sv32_pkg::asid_t      core_req_asid,
    input  sv32_pkg::vpn_t       core_req_vpn,
    output logic                 core_req_ready,
    // core response
    output logic                 core_resp_valid,
    output sv32_pkg::ppn_t       core_resp_ppn,
    output logic                 core_resp_page_fault,
    // L2 TLB request
    output logic                 l2_tlb_req_valid,
    output sv32_pkg::asid_t      l2_tlb_req_asid,
    output sv32_pkg::vpn_t       l2_tlb_req_vpn,
    input  logic                 l2_tlb_req_ready,
    // L2 TLB response, single-cycle pulse
    input  logic                 l2_tlb_resp_valid,
    input  sv32_pkg::asid_t      l2_tlb_resp_asid,
    input  sv32_pkg::vpn_t       l2_tlb_resp_vpn,
    input  sv32_pkg::pte_t       l2_tlb_resp_pte,
    input  logic                 l2_tlb_resp_is_superpage,
    // sfence invalidation
    input  logic                 sfence_inv_valid,
    input  sv32_pkg::asid_t      sfence_inv_asid,
    input  sv32_pkg::vpn_t       sfence_inv_vpn,
    output logic                 sfence_inv_ready
);

    tlb_array_if #(.ASSOC(`ITLB_4KB_ASSOC)) arr_4kb_if ();
    tlb_array_if #(.ASSOC(`ITLB_4MB_ASSOC)) arr_4mb_if ();

    itlb_ctrl i_itlb_ctrl (
        .arr_4kb (arr_4kb_if.ctrl),
        .arr_4mb (arr_4mb_if.ctrl),
        .*
    );

    itlb_array #(
        .NUM_SETS  (`ITLB_4KB_ENTRIES / `ITLB_4KB_ASSOC),
        .ASSOC     (`ITLB_4KB_ASSOC),
        .SUPERPAGE (1'b0)
    ) i_array_4kb (
        .CLK  (CLK),
        .nRST (nRST),
        .port (arr_4kb_if.array)
    );

    itlb_array #(
        .NUM_SETS  (`ITLB_4MB_ENTRIES / `ITLB_4MB_ASSOC),
        .ASSOC     (`ITLB_4MB_ASSOC),
        .SUPERPAGE (1'b1)
    ) i_array_4mb (
        .CLK  (CLK),
        .nRST (nRST),
        .port (arr_4mb_if.array)
    );

endmodule

//--- hw/sv32_pkg.sv
/* Sv32 paging types */

package sv32_pkg;

    // --------------------------------------------------
    // address fields

    // virtual page number, vpn1 in [19:10], vpn0 in [9:0]
    typedef logic [19:0] vpn_t;

    // physical page number, ppn1 in [21:10], ppn0 in [9:0]
    typedef logic [21:0] ppn_t;

    typedef logic [8:0] asid_t;

    // privilege of the fetch
    typedef logic [1:0] exec_mode_t;

    localparam exec_mode_t MODE_USER       = 2'd0;
    localparam exec_mode_t MODE_SUPERVISOR = 2'd1;

    // --------------------------------------------------
    // page table entry, as read from memory

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

endpackage

//--- hw/tlb_array_if.sv
/* Controller to array link */

`include "itlb_cfg.svh"

interface tlb_array_if #(
    parameter int ASSOC = `ITLB_4KB_ASSOC
) ();

    // lookup, shared by core requests and sfence
    sv32_pkg::vpn_t        rd_vpn;
    sv32_pkg::asid_t       rd_asid;

    // combinational lookup result
    logic                  hit;
    itlb_pkg::tlb_entry_t  hit_entry;
    logic [ASSOC-1:0]      sf_hit_way_mask;

    // write port, fill into the PLRU victim or clear masked ways
    logic                  wr_valid;
    sv32_pkg::vpn_t        wr_vpn;
    sv32_pkg::asid_t       wr_asid;
    itlb_pkg::tlb_entry_t  wr_entry;
    logic                  wr_fill;
    logic [ASSOC-1:0]      wr_inv_mask;

    // PLRU update for the way that hit
    logic                  touch_valid;

    modport ctrl (
        output rd_vpn, rd_asid, wr_valid, wr_vpn, wr_asid, wr_entry, wr_fill,
        output wr_inv_mask, touch_valid,
        input  hit, hit_entry, sf_hit_way_mask
    );

    modport array (
        input  rd_vpn, rd_asid, wr_valid, wr_vpn, wr_asid, wr_entry, wr_fill,
        input  wr_inv_mask, touch_valid,
        output hit, hit_entry, sf_hit_way_mask
    );

endinterface

//--- include/itlb_cfg.svh
/* ITLB array geometry */

`ifndef ITLB_CFG_SVH
`define ITLB_CFG_SVH

// --------------------------------------------------
// 4KB page array

// total entries over all sets
`define ITLB_4KB_ENTRIES 16
// ways per set, power of two
`define ITLB_4KB_ASSOC 4

// --------------------------------------------------
// 4MB superpage array

`define ITLB_4MB_ENTRIES 4
`define ITLB_4MB_ASSOC 2

// sets per array follow as ENTRIES / ASSOC

`endif

//--- src.f
+incdir+include
hw/sv32_pkg.sv
hw/itlb_pkg.sv
hw/tlb_array_if.sv
hw/itlb_array.sv
hw/itlb_ctrl.sv
hw/itlb_top.sv
test/tb_clk_gen.sv
test/itlb_tb.sv

//--- test/itlb_tb.sv
/* ITLB random testbench */

`include "itlb_cfg.svh"

module itlb_tb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_OPS    = 400;
    localparam int POOL_SIZE  = 12;

    logic                 CLK;
    logic                 nRST;
    logic                 core_req_valid;
    sv32_pkg::exec_mode_t core_req_exec_mode;
    logic                 core_req_virtual_mode;
    sv32_pkg::asid_t      core_req_asid;
    sv32_pkg::vpn_t       core_req_vpn;
    logic                 core_req_ready;
    logic                 core_resp_valid;
    sv32_pkg::ppn_t       core_resp_ppn;
    logic                 core_resp_page_fault;
    logic                 l2_tlb_req_valid;
    sv32_pkg::asid_t      l2_tlb_req_asid;
    sv32_pkg::vpn_t       l2_tlb_req_vpn;
    logic                 l2_tlb_req_ready;
    logic                 l2_tlb_resp_valid;
    sv32_pkg::asid_t      l2_tlb_resp_asid;
    sv32_pkg::vpn_t       l2_tlb_resp_vpn;
    sv32_pkg::pte_t       l2_tlb_resp_pte;
    logic                 l2_tlb_resp_is_superpage;
    logic                 sfence_inv_valid;
    sv32_pkg::asid_t      sfence_inv_asid;
    sv32_pkg::vpn_t       sfence_inv_vpn;
    logic                 sfence_inv_ready;

    // page table seen by the L2 model
    sv32_pkg::vpn_t  pool_vpn     [POOL_SIZE];
    sv32_pkg::asid_t pool_asid    [POOL_SIZE];
    sv32_pkg::pte_t  pool_pte     [POOL_SIZE];
    logic            pool_super   [POOL_SIZE];
    // pairs sharing a global page form one group
    int              pool_group   [POOL_SIZE];
    int              pool_partner [POOL_SIZE];
    logic            seen         [POOL_SIZE];
    logic            flushed      [POOL_SIZE];
    int              last_idx;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) i_clk_gen (.CLK(CLK), .nRST(nRST));

    itlb_top i_dut (.*);

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic set_pair(input int idx, input sv32_pkg::vpn_t vpn, input sv32_pkg::asid_t asid,
                            input logic is_super, input int group, input sv32_pkg::ppn_t ppn,
                            input logic g, input logic u, input logic x, input logic v);
        pool_vpn[idx]     = vpn;
        pool_asid[idx]    = asid;
        pool_super[idx]   = is_super;
        pool_group[idx]   = group;
        pool_partner[idx] = group;
        if (group != idx) begin
            pool_partner[group] = idx;
        end
        // ppn, rsw, d, a, g, u, x, w, r, v
        pool_pte[idx] = {ppn, 2'b00, 1'b0, 1'b1, g, u, x, 1'b0, 1'b1, v};
    endtask

    // distinct vpn1 everywhere so no superpage covers another pair
    task automatic build_pool();
        set_pair(0,  20'h00401, 9'h001, 1'b0, 0,  22'h012345, 1'b0, 1'b1, 1'b1, 1'b1);
        set_pair(1,  20'h00C02, 9'h001, 1'b0, 1,  22'h023456, 1'b0, 1'b0, 1'b1, 1'b1);
        set_pair(2,  20'h01403, 9'h002, 1'b0, 2,  22'h034567, 1'b0, 1'b1, 1'b0, 1'b1);
        set_pair(3,  20'h01C04, 9'h003, 1'b0, 3,  22'h045678, 1'b1, 1'b0, 1'b1, 1'b1);
        set_pair(4,  20'h02405, 9'h004, 1'b0, 4,  22'h056789, 1'b0, 1'b1, 1'b1, 1'b0);
        set_pair(5,  20'h02C06, 9'h005, 1'b1, 5,  22'h2AF000, 1'b0, 1'b1, 1'b1, 1'b1);
        set_pair(6,  20'h03407, 9'h006, 1'b1, 6,  22'h048C04, 1'b0, 1'b0, 1'b1, 1'b1);
        set_pair(7,  20'h03C08, 9'h007, 1'b1, 7,  22'h0F1400, 1'b1, 1'b0, 1'b1, 1'b1);
        set_pair(8,  20'h04409, 9'h008, 1'b0, 8,  22'h0789AB, 1'b0, 1'b0, 1'b1, 1'b1);
        set_pair(9,  20'h04C0A, 9'h009, 1'b0, 9,  22'h089ABC, 1'b0, 1'b1, 1'b1, 1'b1);
        // global pages again under another asid with the same low index bits
        set_pair(10, 20'h01C04, 9'h007, 1'b0, 3,  22'h045678, 1'b1, 1'b0, 1'b1, 1'b1);
        set_pair(11, 20'h03C08, 9'h0FF, 1'b1, 7,  22'h0F1400, 1'b1, 1'b0, 1'b1, 1'b1);
    endtask

    function automatic int find_pair(input sv32_pkg::vpn_t vpn, input sv32_pkg::asid_t asid);
        for (int i = 0; i < POOL_SIZE; i++) begin
            if (pool_vpn[i] == vpn && pool_asid[i] == asid) begin
                return i;
            end
        end
        return -1;
    endfunction

    // reference model, {fault, ppn}
    function automatic logic [22:0] expected_resp(input int idx, input sv32_pkg::exec_mode_t mode);
        logic [31:0] pte;
        logic        fault;
        logic [21:0] ppn;
        pte   = pool_pte[idx];
        fault = !pte[0] || !pte[3];
        // user needs u set, supervisor needs u clear
        fault = fault || (mode == 2'd0 ? !pte[4] : pte[4]);
        fault = fault || (pool_super[idx] && pte[19:10] != 10'd0);
        ppn   = pool_super[idx] ? {pte[31:20], pool_vpn[idx][9:0]} : pte[31:10];
        return fault ? {1'b1, 22'd0} : {1'b0, ppn};
    endfunction

    // --------------------------------------------------
    // request drivers

    task automatic run_request(input int idx, input logic virt, input sv32_pkg::vpn_t bare_vpn,
                               input sv32_pkg::exec_mode_t mode);
        sv32_pkg::vpn_t  vpn;
        sv32_pkg::asid_t asid;
        logic [22:0]     exp;
        logic            expect_hit;
        logic            expect_miss;
        logic            got_miss;
        int              grp;
        int              lat;
        int              l2_lat;
        if (virt) begin
            vpn         = pool_vpn[idx];
            asid        = pool_asid[idx];
            grp         = pool_group[idx];
            exp         = expected_resp(idx, mode);
            expect_hit  = last_idx >= 0 && pool_group[last_idx] == grp;
            expect_miss = !seen[grp] || flushed[grp];
        end else begin
            vpn         = bare_vpn;
            asid        = sv32_pkg::asid_t'($urandom);
            grp         = 0;
            exp         = {1'b0, 2'b00, bare_vpn};
            expect_hit  = 1'b1;
            expect_miss = 1'b0;
        end
        @(posedge CLK);
        #5;
        core_req_valid        = 1'b1;
        core_req_virtual_mode = virt;
        core_req_exec_mode    = mode;
        core_req_vpn          = vpn;
        core_req_asid         = asid;
        @(negedge CLK);
        while (!core_req_ready) begin
            check_equal(core_resp_valid, 1'b0, "core_resp_valid before acceptance");
            @(negedge CLK);
        end
        @(posedge CLK);
        #5;
        core_req_valid = 1'b0;
        got_miss = 1'b0;
        lat      = 0;
        l2_lat   = -1;
        do begin
            @(negedge CLK);
            lat++;
            if (l2_tlb_req_valid) begin
                got_miss = 1'b1;
                check_equal(l2_tlb_req_vpn, vpn, "l2_tlb_req_vpn");
                check_equal(l2_tlb_req_asid, asid, "l2_tlb_req_asid");
            end
            if (l2_tlb_resp_valid) begin
                l2_lat = lat;
            end
        end while (!core_resp_valid);
        if (got_miss) begin
            check_equal(l2_lat >= 0, 1'b1, "L2 response seen before core response");
            check_equal(lat - l2_lat, 2, "cycles from L2 response to core response");
        end
        if (expect_hit) begin
            check_equal(got_miss, 1'b0, "L2 request on a hit");
            check_equal(lat, 1, "hit latency");
        end
        if (expect_miss) begin
            check_equal(got_miss, 1'b1, "L2 request on a miss");
        end
        check_equal(core_resp_page_fault, exp[22], "core_resp_page_fault");
        check_equal(core_resp_ppn, exp[21:0], "core_resp_ppn");
        if (virt) begin
            seen[grp]    = 1'b1;
            flushed[grp] = 1'b0;
            last_idx     = idx;
        end
    endtask

    task automatic run_sfence(input int idx);
        @(posedge CLK);
        #5;
        sfence_inv_valid = 1'b1;
        sfence_inv_vpn   = pool_vpn[idx];
        sfence_inv_asid  = pool_asid[idx];
        @(negedge CLK);
        while (!sfence_inv_ready) begin
            @(negedge CLK);
        end
        check_equal(core_req_ready, 1'b0, "core_req_ready in sfence accept cycle");
        @(posedge CLK);
        #5;
        sfence_inv_valid = 1'b0;
        @(negedge CLK);
        check_equal(sfence_inv_ready, 1'b0, "sfence_inv_ready in clear cycle");
        // next lookup only after the clear is written
        while (!sfence_inv_ready) begin
            @(negedge CLK);
        end
        flushed[pool_group[idx]] = 1'b1;
        last_idx = -1;
    endtask

    // --------------------------------------------------
    // L2 TLB model

    initial begin : l2_responder
        int              idx;
        int unsigned     delay;
        sv32_pkg::vpn_t  req_vpn;
        sv32_pkg::asid_t req_asid;
        l2_tlb_req_ready         = 1'b0;
        l2_tlb_resp_valid        = 1'b0;
        l2_tlb_resp_asid         = '0;
        l2_tlb_resp_vpn          = '0;
        l2_tlb_resp_pte          = '0;
        l2_tlb_resp_is_superpage = 1'b0;
        forever begin
            @(negedge CLK);
            if (nRST && l2_tlb_req_valid) begin
                req_vpn  = l2_tlb_req_vpn;
                req_asid = l2_tlb_req_asid;
                idx      = find_pair(req_vpn, req_asid);
                if (idx < 0) begin
                    $display("L2 request at time %0t names a page outside the table", $time);
                    abort_run();
                end
                delay = $urandom_range(3, 0);
                repeat (delay + 1) @(posedge CLK);
                #5;
                l2_tlb_req_ready = 1'b1;
                @(posedge CLK);
                #5;
                l2_tlb_req_ready = 1'b0;
                delay = $urandom_range(4, 1);
                repeat (delay) @(posedge CLK);
                #5;
                l2_tlb_resp_valid        = 1'b1;
                l2_tlb_resp_asid         = req_asid;
                l2_tlb_resp_vpn          = req_vpn;
                l2_tlb_resp_pte          = pool_pte[idx];
                l2_tlb_resp_is_superpage = pool_super[idx];
                @(posedge CLK);
                #5;
                l2_tlb_resp_valid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(NUM_OPS * 40 * CLK_PERIOD);
        $display("Run timed out after %0d time units with operations left", $time);
        abort_run();
    end

    // --------------------------------------------------
    // main sequence

    initial begin : stimulus
        int unsigned          sel;
        int                   idx;
        sv32_pkg::exec_mode_t mode;
        core_req_valid        = 1'b0;
        core_req_exec_mode    = sv32_pkg::MODE_USER;
        core_req_virtual_mode = 1'b0;
        core_req_asid         = '0;
        core_req_vpn          = '0;
        sfence_inv_valid      = 1'b0;
        sfence_inv_asid       = '0;
        sfence_inv_vpn        = '0;
        last_idx              = -1;
        void'($urandom(32'heb9e));
        build_pool();
        for (int i = 0; i < POOL_SIZE; i++) begin
            seen[i]    = 1'b0;
            flushed[i] = 1'b0;
        end
        $display("ITLB 4KB %0d x %0d-way, 4MB %0d x %0d-way", `ITLB_4KB_ENTRIES,
                 `ITLB_4KB_ASSOC, `ITLB_4MB_ENTRIES, `ITLB_4MB_ASSOC);
        @(posedge nRST);
        @(negedge CLK);
        check_equal(core_req_ready, 1'b1, "core_req_ready after reset");
        check_equal(sfence_inv_ready, 1'b1, "sfence_inv_ready after reset");
        check_equal(core_resp_valid, 1'b0, "core_resp_valid after reset");
        check_equal(l2_tlb_req_valid, 1'b0, "l2_tlb_req_valid after reset");
        for (int op = 0; op < NUM_OPS; op++) begin
            sel  = $urandom_range(19, 0);
            idx  = $urandom_range(POOL_SIZE - 1, 0);
            mode = sv32_pkg::exec_mode_t'($urandom_range(1, 0));
            if (sel < 2) begin
                // flush what was just translated when possible
                run_sfence(last_idx >= 0 ? last_idx : idx);
            end else if (sel < 4) begin
                run_request(0, 1'b0, sv32_pkg::vpn_t'($urandom), mode);
            end else if (sel < 10 && last_idx >= 0) begin
                idx = $urandom_range(1, 0) ? pool_partner[last_idx] : last_idx;
                run_request(idx, 1'b1, '0, mode);
            end else begin
                run_request(idx, 1'b1, '0, mode);
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

//--- test/tb_clk_gen.sv
/* Testbench clock and reset */

module tb_clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever begin
            #(PERIOD / 2) CLK = ~CLK;
        end
    end

    // release just after a rising edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #5;
        nRST = 1'b1;
    end

endmodule
